/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_core
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = TEST OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
+incdir+logic
logic/rv_pkg.sv
logic/ifu_de.sv
logic/de.sv
logic/regs.sv
logic/de_alu.sv
logic/core_top.sv
sim/tb_core.sv

/* logic/core_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv_defs.svh"

module core_top (
    input  wire               clk,
    input  wire               reset,

    // instruction bus
    output logic [`XLEN-1:0]  iwb_adr,
    output logic              iwb_cyc,
    output logic              iwb_stb,
    input  wire  [`XLEN-1:0]  iwb_dat_i,
    input  wire               iwb_ack,

    // writeback
    output logic              wb_en,
    output logic [4:0]        wb_addr,
    output logic [`XLEN-1:0]  wb_data,

    // retire trace
    output logic              retire_valid,
    output logic [`XLEN-1:0]  retire_pc,
    output logic [`XLEN-1:0]  retire_inst
);

    import rv_pkg::*;

    logic [`XLEN-1:0] de_pc;
    logic [`XLEN-1:0] de_inst;
    logic             inst_valid;
    logic [4:0]       rd_addr1;
    logic [4:0]       rd_addr2;
    logic [`XLEN-1:0] rd_data1;
    logic [`XLEN-1:0] rd_data2;
    alu_op_e          alu_op;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic             rd_reg_en;
    logic [4:0]       rd_reg_addr;
    logic [`XLEN-1:0] de_pc_o;
    logic [`XLEN-1:0] de_inst_o;

    ifu_de u_ifu_de (
        .clk        (clk),
        .reset      (reset),
        .iwb_adr    (iwb_adr),
        .iwb_cyc    (iwb_cyc),
        .iwb_stb    (iwb_stb),
        .iwb_dat_i  (iwb_dat_i),
        .iwb_ack    (iwb_ack),
        .de_pc      (de_pc),
        .de_inst    (de_inst),
        .inst_valid (inst_valid)
    );

    de u_de (
        .de_pc       (de_pc),
        .de_inst     (de_inst),
        .rd_data1    (rd_data1),
        .rd_data2    (rd_data2),
        .rd_addr1    (rd_addr1),
        .rd_addr2    (rd_addr2),
        .alu_op      (alu_op),
        .op1         (op1),
        .op2         (op2),
        .rd_reg_en   (rd_reg_en),
        .rd_reg_addr (rd_reg_addr),
        .de_pc_o     (de_pc_o),
        .de_inst_o   (de_inst_o)
    );

    regs u_regs (
        .clk      (clk),
        .reset    (reset),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    de_alu u_de_alu (
        .inst_valid   (inst_valid),
        .alu_op       (alu_op),
        .op1          (op1),
        .op2          (op2),
        .rd_reg_en    (rd_reg_en),
        .rd_reg_addr  (rd_reg_addr),
        .de_pc_o      (de_pc_o),
        .de_inst_o    (de_inst_o),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst)
    );

endmodule

`default_nettype wire

/* logic/de.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv_defs.svh"

module de (
    // from ifu_de
    input  wire  [`XLEN-1:0] de_pc,
    input  wire  [`XLEN-1:0] de_inst,

    // from regs
    input  wire  [`XLEN-1:0] rd_data1,
    input  wire  [`XLEN-1:0] rd_data2,

    // to regs
    output logic [4:0]       rd_addr1,
    output logic [4:0]       rd_addr2,

    // to de_alu
    output rv_pkg::alu_op_e  alu_op,
    output logic [`XLEN-1:0] op1,
    output logic [`XLEN-1:0] op2,
    output logic             rd_reg_en,
    output logic [4:0]       rd_reg_addr,
    output logic [`XLEN-1:0] de_pc_o,
    output logic [`XLEN-1:0] de_inst_o
);

    import rv_pkg::*;

    inst_t inst;
    logic  legal;
    logic  alt;

    assign inst = de_inst;
    // bit 30 picks SUB and SRA/SRAI
    assign alt  = inst.r.funct7[5];

    always_comb begin
        legal    = 1'b0;
        alu_op   = ALU_NONE;
        rd_addr1 = 5'd0;
        rd_addr2 = 5'd0;
        op1      = '0;
        op2      = '0;
        case (inst.r.opcode)
            `OPC_OP_IMM: begin
                legal    = 1'b1;
                rd_addr1 = inst.i.rs1;
                op1      = rd_data1;
                op2      = {{20{inst.i.imm12[11]}}, inst.i.imm12};
                case (inst.i.funct3)
                    `F3_ADD:  alu_op = ALU_ADD;
                    `F3_SLT:  alu_op = ALU_SLT;
                    `F3_SLTU: alu_op = ALU_SLTU;
                    `F3_XOR:  alu_op = ALU_XOR;
                    `F3_OR:   alu_op = ALU_OR;
                    `F3_AND:  alu_op = ALU_AND;
                    `F3_SLL: begin
                        alu_op = ALU_SLL;
                        op2    = {27'd0, inst.i.imm12[4:0]};
                    end
                    default: begin
                        // F3_SR
                        alu_op = alt ? ALU_SRA : ALU_SRL;
                        op2    = {27'd0, inst.i.imm12[4:0]};
                    end
                endcase
            end
            `OPC_OP: begin
                if (inst.r.funct7 == `F7_BASE || inst.r.funct7 == `F7_ALT) begin
                    legal    = 1'b1;
                    rd_addr1 = inst.r.rs1;
                    rd_addr2 = inst.r.rs2;
                    op1      = rd_data1;
                    op2      = rd_data2;
                    case (inst.r.funct3)
                        `F3_ADD:  alu_op = alt ? ALU_SUB : ALU_ADD;
                        `F3_SLL:  alu_op = ALU_SLL;
                        `F3_SLT:  alu_op = ALU_SLT;
                        `F3_SLTU: alu_op = ALU_SLTU;
                        `F3_XOR:  alu_op = ALU_XOR;
                        `F3_SR:   alu_op = alt ? ALU_SRA : ALU_SRL;
                        `F3_OR:   alu_op = ALU_OR;
                        default:  alu_op = ALU_AND;
                    endcase
                end
            end
            default: begin
                // anything else retires as a no-op
                legal = 1'b0;
            end
        endcase
    end

    // x0 is never a destination
    assign rd_reg_en   = legal && (inst.r.rd != 5'd0);
    assign rd_reg_addr = rd_reg_en ? inst.r.rd : 5'd0;

    assign de_pc_o   = de_pc;
    assign de_inst_o = de_inst;

endmodule

`default_nettype wire

/* logic/de_alu.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv_defs.svh"

module de_alu (
    // from ifu_de
    input  wire              inst_valid,

    // from de
    input  wire rv_pkg::alu_op_e alu_op,
    input  wire  [`XLEN-1:0] op1,
    input  wire  [`XLEN-1:0] op2,
    input  wire              rd_reg_en,
    input  wire  [4:0]       rd_reg_addr,
    input  wire  [`XLEN-1:0] de_pc_o,
    input  wire  [`XLEN-1:0] de_inst_o,

    // writeback to regs
    output logic             wb_en,
    output logic [4:0]       wb_addr,
    output logic [`XLEN-1:0] wb_data,

    // trace port
    output logic             retire_valid,
    output logic [`XLEN-1:0] retire_pc,
    output logic [`XLEN-1:0] retire_inst
);

    import rv_pkg::*;

    logic [4:0]       shamt;
    logic [`XLEN-1:0] result;

    assign shamt = op2[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = op1 + op2;
            ALU_SUB:  result = op1 - op2;
            ALU_SLL:  result = op1 << shamt;
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, op1 < op2};
            ALU_XOR:  result = op1 ^ op2;
            ALU_SRL:  result = op1 >> shamt;
            ALU_SRA:  result = $signed(op1) >>> shamt;
            ALU_OR:   result = op1 | op2;
            ALU_AND:  result = op1 & op2;
            default:  result = '0;
        endcase
    end

    // write only when the instruction register holds a fresh word
    assign wb_en   = inst_valid && rd_reg_en;
    assign wb_addr = rd_reg_addr;
    assign wb_data = result;

    // every instruction retires, legal or not
    assign retire_valid = inst_valid;
    assign retire_pc    = inst_valid ? de_pc_o : '0;
    assign retire_inst  = inst_valid ? de_inst_o : '0;

endmodule

`default_nettype wire

/* logic/ifu_de.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv_defs.svh"

module ifu_de (
    input  wire               clk,
    input  wire               reset,

    // wishbone classic read master
    output logic [`XLEN-1:0]  iwb_adr,
    output logic              iwb_cyc,
    output logic              iwb_stb,
    input  wire  [`XLEN-1:0]  iwb_dat_i,
    input  wire               iwb_ack,

    // to de
    output logic [`XLEN-1:0]  de_pc,
    output logic [`XLEN-1:0]  de_inst,

    // to de_alu
    output logic              inst_valid
);

    localparam logic S_IDLE = 1'b0;
    localparam logic S_REQ  = 1'b1;

    logic             state;
    logic [`XLEN-1:0] pc;
    logic             take;

    // instruction accepted at this edge
    assign take = (state == S_REQ) && iwb_ack;

    // idle only right after reset, then one read at a time back to back
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            pc         <= `RESET_PC;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= take;
            if (state == S_IDLE) begin
                state <= S_REQ;
            end
            if (take) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // instruction register and its pc
    always_ff @(posedge clk) begin
        if (take) begin
            de_pc   <= pc;
            de_inst <= iwb_dat_i;
        end
    end

    // next request goes out while the captured one executes
    assign iwb_cyc = (state == S_REQ);
    assign iwb_stb = (state == S_REQ);
    assign iwb_adr = pc;

    // ack only answers an open request
    a_ack_in_stb: assert property (
        @(posedge clk) disable iff (reset)
        iwb_ack |-> (iwb_cyc && iwb_stb)
    );

    // address must not move while the slave waits
    a_adr_hold: assert property (
        @(posedge clk) disable iff (reset)
        (iwb_stb && !iwb_ack) |=> $stable(iwb_adr)
    );

endmodule

`default_nettype wire

/* logic/regs.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv_defs.svh"

module regs (
    input  wire               clk,
    input  wire               reset,

    // read ports, from de
    input  wire  [4:0]        rd_addr1,
    input  wire  [4:0]        rd_addr2,
    output logic [`XLEN-1:0]  rd_data1,
    output logic [`XLEN-1:0]  rd_data2,

    // write port, from de_alu
    input  wire               wb_en,
    input  wire  [4:0]        wb_addr,
    input  wire  [`XLEN-1:0]  wb_data
);

    logic [`XLEN-1:0] xreg [32];

    // x0 stays zero since it is cleared here and decode never targets it
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                xreg[i] <= '0;
            end
        end else if (wb_en) begin
            xreg[wb_addr] <= wb_data;
        end
    end

    assign rd_data1 = xreg[rd_addr1];
    assign rd_data2 = xreg[rd_addr2];

    a_no_x0_write: assert property (
        @(posedge clk) disable iff (reset)
        wb_en |-> (wb_addr != 5'd0)
    );

endmodule

`default_nettype wire

/* logic/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`define XLEN 32

// major opcodes accepted by decode
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011

// funct3 codes, shared by OP and OP-IMM
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

// funct7 codes
// alt selects SUB and SRA
`define F7_BASE 7'b0000000
`define F7_ALT  7'b0100000

`endif

/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // one instruction word, two field layouts
    typedef union packed {
        // register-register layout
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        // register-immediate layout
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } inst_t;

    // operation handed from decode to the ALU
    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SLL  = 4'd3,
        ALU_SLT  = 4'd4,
        ALU_SLTU = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,
        ALU_OR   = 4'd9,
        ALU_AND  = 4'd10
    } alu_op_e;

endpackage

`default_nettype wire

/* sim/tb_core.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv_defs.svh"

module tb_core;

    localparam int PROG_LEN    = 400;
    localparam int MAX_WAIT    = 3;
    localparam int CYCLE_LIMIT = PROG_LEN * (MAX_WAIT + 3) + 50;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] iwb_dat_i = 32'd0;
    logic        iwb_ack = 1'b0;
    wire  [31:0] iwb_adr;
    wire         iwb_cyc;
    wire         iwb_stb;
    wire         wb_en;
    wire  [4:0]  wb_addr;
    wire  [31:0] wb_data;
    wire         retire_valid;
    wire  [31:0] retire_pc;
    wire  [31:0] retire_inst;

    integer      seed;
    logic [31:0] prog [PROG_LEN];
    logic [31:0] model_reg [32];
    int          checks [1:6];
    int          fails [1:6];

    // slave state
    logic        busy;
    logic [1:0]  wait_left;

    // monitor state
    logic        first_cycle_done = 1'b0;
    logic        first_req_seen = 1'b0;
    logic        hold_pending = 1'b0;
    logic [31:0] hold_adr = 32'd0;
    logic        expect_retire = 1'b0;
    logic [31:0] exp_pc = `RESET_PC;
    int          reset_edges = 0;
    int          retired = 0;
    int          cycles = 0;
    int          n_op = 0;
    int          n_imm = 0;
    int          n_x0 = 0;
    int          n_x0_src = 0;
    int          n_illegal = 0;

    core_top dut (
        .clk          (clk),
        .reset        (reset),
        .iwb_adr      (iwb_adr),
        .iwb_cyc      (iwb_cyc),
        .iwb_stb      (iwb_stb),
        .iwb_dat_i    (iwb_dat_i),
        .iwb_ack      (iwb_ack),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst)
    );

    always #4 clk = ~clk;

    task automatic check_word(input int beh, input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        checks[beh]++;
        assert (act === exp) else begin
            fails[beh]++;
            $display("CHECK FAILED time %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input int beh, input string name, input logic exp,
                             input logic act);
        checks[beh]++;
        assert (act === exp) else begin
            fails[beh]++;
            $display("CHECK FAILED time %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_cond(input int beh, input logic ok, input string what);
        checks[beh]++;
        assert (ok) else begin
            fails[beh]++;
            $display("error at time %0t: %s", $time, what);
        end
    endtask

    // 31 ADDIs seed x1..x31, then a random mix
    task automatic build_program();
        logic [31:0] rnd;
        logic [31:0] pick;
        logic [31:0] sel;
        logic [6:0]  f7;
        logic [6:0]  opc;
        for (int k = 0; k < PROG_LEN; k++) begin
            rnd = $random(seed);
            if (k < 31) begin
                prog[k] = {rnd[11:0], 5'd0, `F3_ADD, 5'(k + 1), `OPC_OP_IMM};
            end else begin
                pick = rnd % 32'd100;
                rnd  = $random(seed);
                if (pick < 32'd45) begin
                    sel = $random(seed);
                    // one in eight gets an arbitrary funct7
                    if (sel[2:0] == 3'd0) begin
                        f7 = sel[10:4];
                    end else begin
                        f7 = sel[3] ? `F7_ALT : `F7_BASE;
                    end
                    prog[k] = {f7, rnd[24:7], `OPC_OP};
                end else if (pick < 32'd90) begin
                    prog[k] = {rnd[31:7], `OPC_OP_IMM};
                end else begin
                    opc = rnd[6:0];
                    if (opc == `OPC_OP || opc == `OPC_OP_IMM) begin
                        opc = opc ^ 7'b1000000;
                    end
                    prog[k] = {rnd[31:7], opc};
                end
            end
        end
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] adr);
        int idx;
        idx = int'(adr >> 2);
        if (adr[1:0] == 2'b00 && idx < PROG_LEN) begin
            return prog[idx];
        end
        // beyond the program an unknown opcode that varies with the address
        return {adr[31:7] ^ {18'd0, adr[6:0]}, 7'h7f};
    endfunction

    // reference behavior of OP and OP-IMM per the ISA
    function automatic void model_exec(input logic [31:0] inst, output logic legal,
                                       output logic [31:0] res);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        a     = model_reg[inst[19:15]];
        b     = 32'd0;
        legal = 1'b0;
        res   = 32'd0;
        if (inst[6:0] == `OPC_OP_IMM) begin
            legal = 1'b1;
            b     = {{20{inst[31]}}, inst[31:20]};
        end else if (inst[6:0] == `OPC_OP &&
                     (inst[31:25] == `F7_BASE || inst[31:25] == `F7_ALT)) begin
            legal = 1'b1;
            b     = model_reg[inst[24:20]];
        end
        sh = b[4:0];
        if (legal) begin
            case (inst[14:12])
                `F3_ADD: begin
                    if (inst[6:0] == `OPC_OP && inst[30]) begin
                        res = a - b;
                    end else begin
                        res = a + b;
                    end
                end
                `F3_SLL:  res = a << sh;
                `F3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                `F3_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                `F3_XOR:  res = a ^ b;
                `F3_SR: begin
                    if (inst[30]) begin
                        res = $signed(a) >>> sh;
                    end else begin
                        res = a >> sh;
                    end
                end
                `F3_OR:   res = a | b;
                default:  res = a & b;
            endcase
        end
    endfunction

    task automatic check_result(input logic [31:0] inst);
        logic        legal;
        logic        en_m;
        logic [4:0]  rd_m;
        logic [31:0] res_m;
        int          beh;
        model_exec(inst, legal, res_m);
        rd_m = inst[11:7];
        en_m = legal && (rd_m != 5'd0);
        if (!legal) begin
            beh = 6;
            n_illegal++;
        end else if (rd_m == 5'd0) begin
            beh = 5;
            n_x0++;
        end else if (inst[6:0] == `OPC_OP) begin
            beh = 3;
            n_op++;
        end else begin
            beh = 4;
            n_imm++;
        end
        if (legal && (inst[19:15] == 5'd0 ||
                      (inst[6:0] == `OPC_OP && inst[24:20] == 5'd0))) begin
            n_x0_src++;
        end
        check_bit(beh, "wb_en", en_m, wb_en);
        if (en_m) begin
            check_word(beh, "wb_addr", {27'd0, rd_m}, {27'd0, wb_addr});
            check_word(beh, "wb_data", res_m, wb_data);
            model_reg[rd_m] = res_m;
        end
    endtask

    // wishbone slave with 0 to 3 wait cycles per read
    always @(posedge clk) begin
        logic [1:0]  left;
        logic [31:0] rnd;
        if (reset) begin
            iwb_ack   <= 1'b0;
            busy      <= 1'b0;
            wait_left <= 2'd0;
        end else if (iwb_ack) begin
            iwb_ack <= 1'b0;
            busy    <= 1'b0;
        end else if (iwb_cyc && iwb_stb) begin
            if (busy) begin
                left = wait_left;
            end else begin
                rnd  = $random(seed);
                left = rnd[1:0];
            end
            if (left == 2'd0) begin
                iwb_ack   <= 1'b1;
                iwb_dat_i <= fetch_word(iwb_adr);
            end else begin
                busy      <= 1'b1;
                wait_left <= left - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            reset_edges++;
            // state is unknown until the first reset edge
            if (reset_edges > 1) begin
                check_bit(1, "iwb_cyc", 1'b0, iwb_cyc);
                check_bit(1, "iwb_stb", 1'b0, iwb_stb);
                check_bit(1, "wb_en", 1'b0, wb_en);
                check_bit(1, "retire_valid", 1'b0, retire_valid);
            end
        end else begin
            if (!first_cycle_done) begin
                check_bit(1, "iwb_cyc", 1'b0, iwb_cyc);
                check_bit(1, "iwb_stb", 1'b0, iwb_stb);
                check_bit(1, "wb_en", 1'b0, wb_en);
                check_bit(1, "retire_valid", 1'b0, retire_valid);
                first_cycle_done = 1'b1;
            end else begin
                // fetch runs back to back once started
                check_bit(2, "iwb_cyc", 1'b1, iwb_cyc);
                check_bit(2, "iwb_stb", 1'b1, iwb_stb);
            end
            if (iwb_cyc && !first_req_seen) begin
                check_word(1, "iwb_adr", `RESET_PC, iwb_adr);
                first_req_seen = 1'b1;
            end
            if (hold_pending) begin
                check_word(2, "iwb_adr", hold_adr, iwb_adr);
            end
            hold_pending = iwb_stb && !iwb_ack;
            hold_adr     = iwb_adr;
            // one retirement in the cycle after each accepted ack
            check_bit(2, "retire_valid", expect_retire, retire_valid);
            expect_retire = iwb_ack && iwb_stb;
            if (!retire_valid) begin
                check_bit(2, "wb_en", 1'b0, wb_en);
            end else begin
                check_word(2, "retire_pc", exp_pc, retire_pc);
                check_word(2, "retire_inst", fetch_word(exp_pc), retire_inst);
                check_result(fetch_word(exp_pc));
                exp_pc = exp_pc + 32'd4;
                retired++;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("timeout: %0d of %0d instructions retired in %0d cycles",
                         retired, PROG_LEN, cycles);
                $display("TEST FAILED");
                $finish;
            end
        end
    end

    function automatic string behavior_name(input int b);
        case (b)
            1:       return "reset and first fetch";
            2:       return "fetch sequence under wait states";
            3:       return "R-type results";
            4:       return "I-type results";
            5:       return "x0 handling";
            default: return "illegal instructions";
        endcase
    endfunction

    initial begin
        int total_checks;
        int total_fails;
        seed = 76328;
        for (int r = 0; r < 32; r++) begin
            model_reg[r] = 32'd0;
        end
        build_program();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        while (retired < PROG_LEN) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        check_cond(1, first_req_seen, "no fetch request was seen after reset");
        check_cond(3, n_op > 0, "no OP instruction wrote a register");
        check_cond(4, n_imm > 0, "no OP-IMM instruction wrote a register");
        check_cond(5, n_x0 > 0 && n_x0_src > 0, "x0 was never a target and a source");
        check_cond(6, n_illegal > 0, "no illegal instruction retired");
        total_checks = 0;
        total_fails  = 0;
        for (int b = 1; b <= 6; b++) begin
            $display("behavior %0d, %s: %0d checks, %0d errors",
                     b, behavior_name(b), checks[b], fails[b]);
            total_checks += checks[b];
            total_fails  += fails[b];
        end
        $display("%0d instructions retired, %0d checks, %0d errors",
                 retired, total_checks, total_fails);
        if (total_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
